/* logic/pcProtocolPkg.sv */
`default_nettype none

package pcProtocolPkg;

  ////////////////////////////////////////////////////////////
  // pc word layout

  // command code, top byte of every pc word
  typedef logic [7:0] pcCode;

  // payload carried below the code
  typedef logic [23:0] pcData;

  // one 32-bit word of the pc stream, code first
  typedef struct packed {
    pcCode code;
    pcData data;
  } pcWord;

  ////////////////////////////////////////////////////////////
  // codes understood by the core

  // load the 24-bit offset register
  localparam pcCode codeSetOffset = 8'd0;
  // return data plus offset
  localparam pcCode codeEcho = 8'd1;
  // send data plus offset to the chip output
  localparam pcCode codeToBd = 8'd2;
  // translated spike event from the chip input
  localparam pcCode codeSpike = 8'd3;
  // translated tag count from the chip input
  localparam pcCode codeTag = 8'd4;

endpackage

`default_nettype wire

/* logic/bdProtocolPkg.sv */
`default_nettype none

package bdProtocolPkg;

  ////////////////////////////////////////////////////////////
  // chip output side

  // word sent by the core towards the chip
  typedef logic [20:0] bdOutWord;

  ////////////////////////////////////////////////////////////
  // chip input side

  // spike event, top bit set
  typedef struct packed {
    logic isSpike;
    logic [10:0] neuron;
    // time is a keyword, so the field carries a prefix
    logic [21:0] eventTime;
  } bdSpike;

  // tag count, top bit clear
  typedef struct packed {
    logic isSpike;
    logic [11:0] tagId;
    logic [20:0] count;
  } bdTag;

  // 34-bit chip input word
  // the top bit is shared by both views and selects between them
  typedef union packed {
    bdSpike spike;
    bdTag tag;
  } bdInWord;

endpackage

`default_nettype wire

/* logic/channelSplit.sv */
`default_nettype none

// combinational router, zero cycles
// words whose code equals matchCode go to the hit side
// everything else goes to the miss side
module channelSplit
  import pcProtocolPkg::*;
#(
  parameter pcCode matchCode = 8'hFF
) (
  input wire pcWord inWord,
  input wire inValid,
  output logic inReady,

  output pcWord hitWord,
  output logic hitValid,
  input wire hitReady,

  output pcWord missWord,
  output logic missValid,
  input wire missReady
);

  // code comparison picks the side
  logic hit;

  assign hit = (inWord.code == matchCode);

  // both sides see the word unchanged
  assign hitWord = inWord;
  assign missWord = inWord;

  // only the selected side sees valid
  assign hitValid = inValid && hit;
  assign missValid = inValid && !hit;

  // input ready follows the selected side
  assign inReady = hit ? hitReady : missReady;

endmodule

`default_nettype wire

/* logic/payloadDeserializer.sv */
`default_nettype none

// builds one 34-bit chip input word from two pc payload chunks
// first chunk -> bits 23..0, second chunk low 10 bits -> bits 33..24
module payloadDeserializer
  import pcProtocolPkg::*, bdProtocolPkg::*;
(
  input wire clk,
  input wire reset,

  input wire pcWord chunk,
  input wire chunkValid,
  output logic chunkReady,

  output bdInWord outWord,
  output logic outValid,
  input wire outReady
);

  // set once the low half has been captured
  logic phase;
  // low 24 bits from the first chunk
  pcData lowHalf;
  logic chunkTaken;

  // hold off new chunks while an assembled word waits
  assign chunkReady = !outValid;
  assign chunkTaken = chunkValid && chunkReady;

  ////////////////////////////////////////////////////////////
  // control

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= 1'b0;
      outValid <= 1'b0;
    end else begin
      if (outValid && outReady) begin
        outValid <= 1'b0;
      end
      if (chunkTaken) begin
        // second chunk completes the word
        if (phase) begin
          outValid <= 1'b1;
        end
        phase <= !phase;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // payload

  // chunk code is not looked at, the split already matched it
  always_ff @(posedge clk) begin
    if (chunkTaken) begin
      if (!phase) begin
        lowHalf <= chunk.data;
      end else begin
        // upper 14 bits of the second chunk are dropped
        outWord <= {chunk.data[9:0], lowHalf};
      end
    end
  end

endmodule

`default_nettype wire

/* logic/channelMerge.sv */
`default_nettype none

// two-input round-robin merge into one registered word
module channelMerge
  import pcProtocolPkg::*;
(
  input wire clk,
  input wire reset,

  input wire pcWord aWord,
  input wire aValid,
  output logic aReady,

  input wire pcWord bWord,
  input wire bValid,
  output logic bReady,

  output pcWord outWord,
  output logic outValid,
  input wire outReady
);

  // set when b wins the next tie
  logic preferB;
  // output register empty now or emptied this cycle
  logic canLoad;
  logic grantA;
  logic grantB;

  assign canLoad = !outValid || outReady;

  // at most one grant per cycle
  assign grantA = canLoad && aValid && (!bValid || !preferB);
  assign grantB = canLoad && bValid && (!aValid || preferB);

  assign aReady = grantA;
  assign bReady = grantB;

  ////////////////////////////////////////////////////////////
  // control

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= 1'b0;
      preferB <= 1'b0;
    end else begin
      if (grantA || grantB) begin
        outValid <= 1'b1;
      end else if (outReady) begin
        outValid <= 1'b0;
      end
      // priority only moves on a contested grant
      if (canLoad && aValid && bValid) begin
        preferB <= grantA;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // payload

  always_ff @(posedge clk) begin
    if (grantA) begin
      outWord <= aWord;
    end else if (grantB) begin
      outWord <= bWord;
    end
  end

endmodule

`default_nettype wire

/* logic/coreTranslator.sv */
`default_nettype none

// stand-in for the real core
// runs single-word pc commands and turns chip input words into pc words
module coreTranslator
  import pcProtocolPkg::*, bdProtocolPkg::*;
(
  input wire clk,
  input wire reset,

  input wire pcWord pcIn,
  input wire pcInValid,
  output logic pcInReady,

  output pcWord pcOut,
  output logic pcOutValid,
  input wire pcOutReady,

  output bdOutWord bdOut,
  output logic bdOutValid,
  input wire bdOutReady,

  input wire bdInWord bdIn,
  input wire bdInValid,
  output logic bdInReady
);

  pcData offset;
  // data plus offset, wraps at 2^24
  pcData sum;

  // echo reply register
  pcWord echoWord;
  logic echoValid;
  logic echoReady;

  // translated chip input register
  pcWord xlatWord;
  logic xlatValid;
  logic xlatReady;
  pcWord xlatNext;

  logic pcTaken;
  logic bdTaken;

  assign sum = pcIn.data + offset;

  ////////////////////////////////////////////////////////////
  // pc input decode

  // stall only on the register this code needs
  always_comb begin
    case (pcIn.code)
      codeEcho: pcInReady = !echoValid || echoReady;
      codeToBd: pcInReady = !bdOutValid || bdOutReady;
      // offset writes and unknown codes finish at once
      default: pcInReady = 1'b1;
    endcase
  end

  assign pcTaken = pcInValid && pcInReady;

  ////////////////////////////////////////////////////////////
  // chip input decode

  always_comb begin
    if (bdIn.spike.isSpike) begin
      // low 13 time bits, then neuron
      xlatNext.code = codeSpike;
      xlatNext.data = {bdIn.spike.eventTime[12:0], bdIn.spike.neuron};
    end else begin
      // tag id, then count clamped to 12 bits
      xlatNext.code = codeTag;
      if (bdIn.tag.count > 21'd4095) begin
        xlatNext.data = {bdIn.tag.tagId, 12'hFFF};
      end else begin
        xlatNext.data = {bdIn.tag.tagId, bdIn.tag.count[11:0]};
      end
    end
  end

  assign bdInReady = !xlatValid || xlatReady;
  assign bdTaken = bdInValid && bdInReady;

  ////////////////////////////////////////////////////////////
  // control registers

  always_ff @(posedge clk) begin
    if (reset) begin
      offset <= '0;
      echoValid <= 1'b0;
      bdOutValid <= 1'b0;
      xlatValid <= 1'b0;
    end else begin
      // drain first, a new load in the same cycle wins
      if (echoValid && echoReady) begin
        echoValid <= 1'b0;
      end
      if (bdOutValid && bdOutReady) begin
        bdOutValid <= 1'b0;
      end
      if (xlatValid && xlatReady) begin
        xlatValid <= 1'b0;
      end
      if (pcTaken) begin
        case (pcIn.code)
          codeSetOffset: offset <= pcIn.data;
          codeEcho: echoValid <= 1'b1;
          codeToBd: bdOutValid <= 1'b1;
          default: ;
        endcase
      end
      if (bdTaken) begin
        xlatValid <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // payload registers

  always_ff @(posedge clk) begin
    if (pcTaken && (pcIn.code == codeEcho)) begin
      echoWord <= '{code: codeEcho, data: sum};
    end
    if (pcTaken && (pcIn.code == codeToBd)) begin
      bdOut <= sum[20:0];
    end
    if (bdTaken) begin
      xlatWord <= xlatNext;
    end
  end

  // echo and translated words share the pc output
  channelMerge replyMerge (
    .clk(clk),
    .reset(reset),
    .aWord(echoWord),
    .aValid(echoValid),
    .aReady(echoReady),
    .bWord(xlatWord),
    .bValid(xlatValid),
    .bReady(xlatReady),
    .outWord(pcOut),
    .outValid(pcOutValid),
    .outReady(pcOutReady)
  );

endmodule

`default_nettype wire

/* logic/coreTestHarness.sv */
`default_nettype none

// core wrapped so the pc can play the chip
// pc words with pcToBdCode feed the chip input path
// chip output words return to the pc stamped with bdToPcCode
module coreTestHarness
  import pcProtocolPkg::*, bdProtocolPkg::*;
#(
  parameter pcCode pcToBdCode = 8'hFF,
  parameter pcCode bdToPcCode = 8'hFF
) (
  input wire clk,
  input wire reset,

  input wire pcWord pcIn,
  input wire pcInValid,
  output logic pcInReady,

  output pcWord pcOut,
  output logic pcOutValid,
  input wire pcOutReady
);

  // split -> core
  pcWord corePcIn;
  logic corePcInValid;
  logic corePcInReady;

  // split -> deserializer
  pcWord bdChunk;
  logic bdChunkValid;
  logic bdChunkReady;

  // deserializer -> core
  bdInWord coreBdIn;
  logic coreBdInValid;
  logic coreBdInReady;

  // core -> output merge
  pcWord corePcOut;
  logic corePcOutValid;
  logic corePcOutReady;

  // core chip output and its padded pc form
  bdOutWord coreBdOut;
  logic coreBdOutValid;
  logic coreBdOutReady;
  pcWord bdOutPadded;

  ////////////////////////////////////////////////////////////
  // pc -> chip input

  channelSplit #(
    .matchCode(pcToBdCode)
  ) inputSplit (
    .inWord(pcIn),
    .inValid(pcInValid),
    .inReady(pcInReady),
    .hitWord(bdChunk),
    .hitValid(bdChunkValid),
    .hitReady(bdChunkReady),
    .missWord(corePcIn),
    .missValid(corePcInValid),
    .missReady(corePcInReady)
  );

  payloadDeserializer bdInDeser (
    .clk(clk),
    .reset(reset),
    .chunk(bdChunk),
    .chunkValid(bdChunkValid),
    .chunkReady(bdChunkReady),
    .outWord(coreBdIn),
    .outValid(coreBdInValid),
    .outReady(coreBdInReady)
  );

  ////////////////////////////////////////////////////////////
  // core

  coreTranslator core (
    .clk(clk),
    .reset(reset),
    .pcIn(corePcIn),
    .pcInValid(corePcInValid),
    .pcInReady(corePcInReady),
    .pcOut(corePcOut),
    .pcOutValid(corePcOutValid),
    .pcOutReady(corePcOutReady),
    .bdOut(coreBdOut),
    .bdOutValid(coreBdOutValid),
    .bdOutReady(coreBdOutReady),
    .bdIn(coreBdIn),
    .bdInValid(coreBdInValid),
    .bdInReady(coreBdInReady)
  );

  ////////////////////////////////////////////////////////////
  // chip output -> pc

  // code, three zero pad bits, then the 21-bit word
  assign bdOutPadded = '{code: bdToPcCode, data: {3'b000, coreBdOut}};

  channelMerge outputMerge (
    .clk(clk),
    .reset(reset),
    .aWord(corePcOut),
    .aValid(corePcOutValid),
    .aReady(corePcOutReady),
    .bWord(bdOutPadded),
    .bValid(coreBdOutValid),
    .bReady(coreBdOutReady),
    .outWord(pcOut),
    .outValid(pcOutValid),
    .outReady(pcOutReady)
  );

endmodule

`default_nettype wire

/* tests/coreTestHarnessTb.sv */
`default_nettype none

module coreTestHarnessTb
  import pcProtocolPkg::*, bdProtocolPkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int clkPeriod = 10;
  localparam int wordCount = 400;
  // matches the harness default
  localparam pcCode bdToPcCode = 8'hFF;
  localparam pcCode chipCode = 8'hFF;

  logic clk;
  logic reset;
  pcWord pcIn;
  logic pcInValid;
  logic pcInReady;
  pcWord pcOut;
  logic pcOutValid;
  logic pcOutReady;

  integer seed = 32'h7254_96fc;
  // separate stream for the sink so its draws do not race the driver
  integer readySeed = ~32'h7254_96fc;

  // model state
  pcData offset;
  logic haveLow;
  pcData lowChunk;
  pcWord expEcho[$];
  bdOutWord expBd[$];
  pcWord expXlat[$];

  coreTestHarness UUT (
    .clk(clk),
    .reset(reset),
    .pcIn(pcIn),
    .pcInValid(pcInValid),
    .pcInReady(pcInReady),
    .pcOut(pcOut),
    .pcOutValid(pcOutValid),
    .pcOutReady(pcOutReady)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // failure handling and compare tasks

  task automatic stopRun();
    $display("Done: errors found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic checkPcWord(input pcWord got, input pcWord exp, input string what);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s word %h, expected %h", $time, what, got, exp);
      stopRun();
    end
  endtask

  task automatic checkBdOut(input bdOutWord got, input bdOutWord exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: chip output %h, expected %h", $time, got, exp);
      stopRun();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // reference model

  // bit 33 of the 34-bit chip word picks spike or tag
  function automatic pcWord chipToPc(input logic [33:0] w);
    pcWord r;
    if (w[33]) begin
      // time[12:0] then neuron
      r = '{code: codeSpike, data: {w[12:0], w[32:22]}};
    end else if (w[20:0] > 21'd4095) begin
      r = '{code: codeTag, data: {w[32:21], 12'hFFF}};
    end else begin
      r = '{code: codeTag, data: {w[32:21], w[11:0]}};
    end
    return r;
  endfunction

  // applied in pc input order at acceptance
  task automatic modelWord(input pcWord w);
    pcData s;
    s = w.data + offset;
    if (w.code == chipCode) begin
      if (!haveLow) begin
        lowChunk = w.data;
      end else begin
        expXlat.push_back(chipToPc({w.data[9:0], lowChunk}));
      end
      haveLow = !haveLow;
    end else if (w.code == codeSetOffset) begin
      offset = w.data;
    end else if (w.code == codeEcho) begin
      expEcho.push_back('{code: codeEcho, data: s});
    end else if (w.code == codeToBd) begin
      expBd.push_back(s[20:0]);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // driver is called 1 ns after an edge and returns likewise

  task automatic sendWord(input pcWord w);
    pcIn = w;
    pcInValid = 1'b1;
    @(posedge clk);
    while (!pcInReady) @(posedge clk);
    modelWord(w);
    #1;
    pcInValid = 1'b0;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // sink takes words about 70 percent of cycles
  initial begin
    pcOutReady = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      pcOutReady = ({$random(readySeed)} % 10) < 7;
    end
  end

  ////////////////////////////////////////////////////////////
  // output monitor sorts words by code

  always @(posedge clk) begin
    if (!reset && pcOutValid && pcOutReady) begin
      if (pcOut.code == codeEcho) begin
        if (expEcho.size() == 0) begin
          $display("An echo word %h arrived that was not expected", pcOut);
          stopRun();
        end else begin
          checkPcWord(pcOut, expEcho.pop_front(), "echo");
        end
      end else if (pcOut.code == bdToPcCode) begin
        if (expBd.size() == 0) begin
          $display("A chip output word %h arrived that was not expected", pcOut);
          stopRun();
        end else if (pcOut.data[23:21] !== 3'b000) begin
          $display("Fail at %0d ns: pad bits %b are not zero", $time, pcOut.data[23:21]);
          stopRun();
        end else begin
          checkBdOut(pcOut.data[20:0], expBd.pop_front());
        end
      end else if (pcOut.code == codeSpike || pcOut.code == codeTag) begin
        if (expXlat.size() == 0) begin
          $display("A translated word %h arrived that was not expected", pcOut);
          stopRun();
        end else begin
          checkPcWord(pcOut, expXlat.pop_front(), "translated");
        end
      end else begin
        $display("A word %h with an unexpected code came out", pcOut);
        stopRun();
      end
    end
  end

  // bound from the test length
  initial begin
    #(wordCount * 40 * clkPeriod);
    $display("The run hung and did not finish in time");
    stopRun();
  end

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int sent;
    int pick;
    int drain;
    pcData d;
    reset = 1'b1;
    pcIn = '0;
    pcInValid = 1'b0;
    offset = '0;
    haveLow = 1'b0;
    lowChunk = '0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;
    // idle harness shows nothing out and input open
    repeat (5) begin
      @(posedge clk);
      if (pcOutValid !== 1'b0 || pcInReady !== 1'b1) begin
        $display("Fail at %0d ns: idle state wrong, out valid %b in ready %b",
                 $time, pcOutValid, pcInReady);
        stopRun();
      end
    end
    #1;
    // directed words cover offset wrap and a write between echoes
    sendWord('{code: codeSetOffset, data: 24'h000010});
    sendWord('{code: codeEcho, data: 24'hFFFFF8});
    sendWord('{code: codeSetOffset, data: 24'h123456});
    sendWord('{code: codeEcho, data: 24'h000000});
    sendWord('{code: codeToBd, data: 24'hFFFFFF});
    sendWord('{code: 8'd7, data: 24'hABCDEF});
    sendWord('{code: chipCode, data: 24'h000FFF});
    sendWord('{code: chipCode, data: 24'h0003FF});
    // random traffic
    sent = 0;
    while (sent < wordCount) begin
      pick = {$random(seed)} % 5;
      d = pcData'($random(seed));
      if (pick == 4 && sent < wordCount - 1) begin
        // small counts now and then so tags below the clamp show up
        if ({$random(seed)} % 4 == 0) begin
          d = d & 24'h000FFF;
        end
        sendWord('{code: chipCode, data: d});
        idleCycles({$random(seed)} % 3);
        sendWord('{code: chipCode, data: pcData'($random(seed))});
        sent = sent + 2;
      end else begin
        case (pick)
          0: sendWord('{code: codeSetOffset, data: d});
          1: sendWord('{code: codeEcho, data: d});
          2: sendWord('{code: codeToBd, data: d});
          default: sendWord('{code: 8'd7, data: d});
        endcase
        sent = sent + 1;
      end
      idleCycles({$random(seed)} % 4);
    end
    // bounded wait for the expected words to drain
    drain = 0;
    while (drain < 1000 && (expEcho.size() + expBd.size() + expXlat.size()) != 0) begin
      @(posedge clk);
      drain = drain + 1;
    end
    // a few more cycles to catch stray extra words
    repeat (20) @(posedge clk);
    if ((expEcho.size() + expBd.size() + expXlat.size()) == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Words still expected at the end: echo %0d, chip output %0d, translated %0d",
               expEcho.size(), expBd.size(), expXlat.size());
      stopRun();
    end
  end

endmodule

`default_nettype wire

/* src.f */
logic/pcProtocolPkg.sv
logic/bdProtocolPkg.sv
logic/channelSplit.sv
logic/payloadDeserializer.sv
logic/channelMerge.sv
logic/coreTranslator.sv
logic/coreTestHarness.sv
tests/coreTestHarnessTb.sv
